// File: sd_dat_pkg.sv
`default_nettype none

package sd_dat_pkg;

   // Completion status of a transfer
   typedef enum logic [3:0] {
      success                = 4'd0,
      write_no_data          = 4'd1,
      write_early_boundary   = 4'd2,
      write_late_boundary    = 4'd3,
      write_resp_timeout     = 4'd4,
      write_bad_resp         = 4'd5,
      read_data_not_accepted = 4'd7,
      read_bad_crc           = 4'd8
   } error_code_t;

   // One value across DAT3..DAT0
   typedef logic [3:0] nibble_t;

   // One line's CRC register
   typedef logic [15:0] crc_t;

   // CRC16 of x^16 + x^12 + x^5 + 1
   localparam crc_t crc_polynomial = 16'h1021;

   localparam int crc_nibbles = 16;

   // Bus clocks to wait for the status start bit
   localparam int resp_timeout_ticks = 8;

   // Status bits of an accepted block
   localparam logic [2:0] resp_ok = 3'b010;

endpackage

`default_nettype wire

// File: dat_nibble_counter.sv
`timescale 1ns/1ps
`default_nettype none

module dat_nibble_counter #(
   parameter int word_size = 8,
   parameter int nwr_min = 64
) (
   input  wire        clk,
   input  wire        resetn,
   input  wire        sd_tick,
   input  wire        count_clear,
   input  wire [3:0]  block_size_exp,
   input  wire [31:0] block_count,
   output logic       word_done,
   output logic       block_done,
   output logic       nwr_past,
   output logic       crc_done,
   output logic       resp_timeout,
   output logic       resp_done,
   output logic       last_block
);
   import sd_dat_pkg::*;

   // Room for a 1024-nibble block and for the nwr wait
   localparam int count_width = (nwr_min > 1024) ? $clog2(nwr_min) + 1 : 11;
   localparam int word_nibbles = word_size / 4;
   // Three status bits and the end bit
   localparam int resp_nibbles = 4;

   logic [count_width-1:0] count;
   logic [count_width:0]   count_inc;
   logic [31:0]            blocks_finished;

   assign count_inc = {1'b0, count} + 1'b1;

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         count <= '0;
         nwr_past <= 1'b0;
      end else if (count_clear) begin
         count <= '0;
         nwr_past <= 1'b0;
      end else if (sd_tick) begin
         count <= count_inc[count_width-1:0];
         if (count_inc == (count_width + 1)'(nwr_min))
            nwr_past <= 1'b1;
      end
   end

   assign word_done = (count % count_width'(word_nibbles)) == count_width'(word_nibbles - 1);
   assign block_done = count_inc == ((count_width + 1)'(1) << block_size_exp);
   assign crc_done = count == count_width'(crc_nibbles - 1);
   assign resp_timeout = count == count_width'(resp_timeout_ticks - 1);
   assign resp_done = count == count_width'(resp_nibbles - 1);

   // The sequencer restarts the count at each block boundary
   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn)
         blocks_finished <= '0;
      else if (sd_tick && block_done && count_clear)
         blocks_finished <= blocks_finished + 1'b1;
   end

   assign last_block = blocks_finished >= block_count;

   // The sequencer stops once the last block has finished
   a_blocks_bounded: assert property (@(posedge clk) disable iff (!resetn)
      blocks_finished <= block_count);

endmodule

`default_nettype wire

// File: dat_shift_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dat_shift_buffer #(
   parameter int word_size = 8
) (
   input  wire                  clk,
   input  wire                  resetn,
   input  wire                  sd_tick,
   input  wire                  buffer_enable,
   input  wire                  load_word,
   input  wire [word_size-1:0]  in_tdata,
   input  wire                  in_tlast,
   input  wire sd_dat_pkg::nibble_t dat_in,
   output sd_dat_pkg::nibble_t  top_nibble,
   output logic [word_size-1:0] word_next,
   output logic                 tlast_saved,
   output logic [2:0]           line0_history
);
   logic [word_size-1:0] buffer;

   // Nibbles leave and enter most significant first
   assign word_next = {buffer[word_size-5:0], dat_in};
   assign top_nibble = buffer[word_size-1 -: 4];

   // Cleared outside the phases that use it
   always_ff @(posedge clk) begin
      if (!buffer_enable)
         buffer <= '0;
      else if (sd_tick)
         buffer <= load_word ? in_tdata : word_next;
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         tlast_saved <= 1'b0;
         line0_history <= '0;
      end else if (!buffer_enable) begin
         tlast_saved <= 1'b0;
         line0_history <= '0;
      end else if (sd_tick) begin
         if (load_word)
            tlast_saved <= in_tlast;
         // DAT0 carries the CRC status token
         line0_history <= {line0_history[1:0], dat_in[0]};
      end
   end

endmodule

`default_nettype wire

// File: dat_crc16_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dat_crc16_bank (
   input  wire                 clk,
   input  wire                 resetn,
   input  wire                 crc_clear,
   input  wire                 sd_tick,
   input  wire sd_dat_pkg::nibble_t crc_in,
   output sd_dat_pkg::nibble_t crc_msb,
   output logic                crc_good
);
   import sd_dat_pkg::*;

   wire [3:0] msb_bits;
   wire [3:0] line_zero;

   for (genvar i = 0; i < 4; i++) begin : g_line
      crc_t crc;
      logic feedback;

      // Feeding the msb back gives zero feedback, so the CRC shifts out
      assign feedback = crc[15] ^ crc_in[i];

      always_ff @(posedge clk or negedge resetn) begin
         if (!resetn)
            crc <= '0;
         else if (crc_clear)
            crc <= '0;
         else if (sd_tick)
            crc <= {crc[14:0], 1'b0} ^ (feedback ? crc_polynomial : crc_t'(0));
      end

      assign msb_bits[i] = crc[15];
      assign line_zero[i] = crc == '0;
   end

   assign crc_msb = msb_bits;
   // Remainder is zero once the received CRC has gone in
   assign crc_good = &line_zero;

endmodule

`default_nettype wire

// File: dat_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dat_sequencer #(
   parameter int word_size = 8
) (
   input  wire                  clk,
   input  wire                  resetn,
   input  wire                  sd_tick,
   input  wire                  read_mode,
   input  wire                  in_tvalid,
   input  wire                  out_tready,
   input  wire sd_dat_pkg::nibble_t dat_in,
   input  wire                  word_done,
   input  wire                  block_done,
   input  wire                  nwr_past,
   input  wire                  crc_done,
   input  wire                  resp_timeout,
   input  wire                  resp_done,
   input  wire                  last_block,
   input  wire sd_dat_pkg::nibble_t top_nibble,
   input  wire [word_size-1:0]  word_next,
   input  wire                  tlast_saved,
   input  wire [2:0]            line0_history,
   input  wire sd_dat_pkg::nibble_t crc_msb,
   input  wire                  crc_good,
   output logic                 count_clear,
   output logic                 load_word,
   output logic                 buffer_enable,
   output logic                 crc_clear,
   output sd_dat_pkg::nibble_t  crc_in,
   output logic                 in_tready,
   output logic                 out_tvalid,
   output logic [word_size-1:0] out_tdata,
   output logic                 out_tlast,
   output sd_dat_pkg::nibble_t  dat_out,
   output logic                 dat_oe,
   output logic                 done,
   output logic                 done_new,
   output sd_dat_pkg::error_code_t error_code
);
   import sd_dat_pkg::*;

   typedef enum logic [3:0] {
      state_initial,
      state_done,
      state_write_pending_device,
      state_write_pending_host,
      state_write_start_bit,
      state_write_data,
      state_write_crc,
      state_write_end_bit,
      state_write_resp_pending,
      state_write_resp_start,
      state_write_resp,
      state_read_pending,
      state_read_data,
      state_read_crc,
      state_read_end_bit
   } state_t;

   state_t      state;
   state_t      state_next;
   logic        finish;
   error_code_t finish_code;
   logic        set_out_tvalid;
   logic        word_capture;
   nibble_t     dat_out_next;
   logic        dat_oe_next;

   assign buffer_enable = state inside {state_write_pending_host, state_write_start_bit,
                                        state_write_data, state_write_resp, state_read_data};
   assign crc_clear = !(state inside {state_write_data, state_write_crc, state_read_data,
                                      state_read_crc, state_read_end_bit});
   assign in_tready = sd_tick && load_word;
   assign word_capture = state == state_read_data && sd_tick && word_done;

   always_comb begin
      case (state)
         state_write_data: crc_in = top_nibble;
         state_write_crc:  crc_in = crc_msb;
         default:          crc_in = dat_in;
      endcase
   end

   always_comb begin
      state_next = state;
      count_clear = 1'b0;
      load_word = 1'b0;
      set_out_tvalid = 1'b0;
      finish = 1'b0;
      finish_code = success;
      case (state)
         state_initial:
            state_next = read_mode ? state_read_pending : state_write_pending_device;
         // Card holds DAT0 low while busy
         state_write_pending_device: begin
            count_clear = 1'b1;
            if (sd_tick && dat_in[0])
               state_next = state_write_pending_host;
         end
         state_write_pending_host:
            if (sd_tick && in_tvalid && nwr_past)
               state_next = state_write_start_bit;
         state_write_start_bit: begin
            load_word = 1'b1;
            count_clear = 1'b1;
            if (sd_tick)
               state_next = state_write_data;
         end
         state_write_data: begin
            load_word = word_done && !block_done;
            if (in_tready && !in_tvalid) begin
               finish = 1'b1;
               finish_code = write_no_data;
            end else if (sd_tick && block_done) begin
               count_clear = 1'b1;
               if (!tlast_saved) begin
                  finish = 1'b1;
                  finish_code = write_late_boundary;
               end else begin
                  state_next = state_write_crc;
               end
            end else if (sd_tick && word_done && tlast_saved) begin
               finish = 1'b1;
               finish_code = write_early_boundary;
            end
         end
         state_write_crc:
            if (sd_tick && crc_done)
               state_next = state_write_end_bit;
         state_write_end_bit: begin
            count_clear = 1'b1;
            if (sd_tick)
               state_next = state_write_resp_pending;
         end
         state_write_resp_pending:
            if (sd_tick && !dat_in[0]) begin
               state_next = state_write_resp_start;
            end else if (sd_tick && resp_timeout) begin
               finish = 1'b1;
               finish_code = write_resp_timeout;
            end
         // One clock between bus clocks to restart the count
         state_write_resp_start: begin
            count_clear = 1'b1;
            state_next = state_write_resp;
         end
         state_write_resp:
            if (sd_tick && resp_done) begin
               if (line0_history != resp_ok) begin
                  finish = 1'b1;
                  finish_code = write_bad_resp;
               end else if (last_block) begin
                  finish = 1'b1;
               end else begin
                  state_next = state_write_pending_device;
               end
            end
         state_read_pending: begin
            count_clear = 1'b1;
            if (sd_tick && !dat_in[0])
               state_next = state_read_data;
         end
         state_read_data:
            if (sd_tick) begin
               // Last word waits for the CRC check
               set_out_tvalid = word_done && !block_done;
               if (word_done && out_tvalid) begin
                  finish = 1'b1;
                  finish_code = read_data_not_accepted;
               end else if (block_done) begin
                  count_clear = 1'b1;
                  state_next = state_read_crc;
               end
            end
         state_read_crc:
            if (sd_tick && crc_done)
               state_next = state_read_end_bit;
         state_read_end_bit:
            if (sd_tick) begin
               if (!crc_good || dat_in != 4'hf) begin
                  finish = 1'b1;
                  finish_code = read_bad_crc;
               end else if (out_tvalid) begin
                  finish = 1'b1;
                  finish_code = read_data_not_accepted;
               end else begin
                  set_out_tvalid = 1'b1;
                  if (last_block)
                     finish = 1'b1;
                  else
                     state_next = state_read_pending;
               end
            end
         default: ;
      endcase
      if (finish)
         state_next = state_done;
   end

   always_comb begin
      dat_oe_next = 1'b1;
      case (state)
         state_write_start_bit: dat_out_next = '0;
         state_write_data:      dat_out_next = top_nibble;
         state_write_crc:       dat_out_next = crc_msb;
         state_write_pending_host, state_write_end_bit:
            dat_out_next = '1;
         default: begin
            dat_out_next = '1;
            dat_oe_next = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state <= state_initial;
         dat_out <= '1;
         dat_oe <= 1'b0;
         done <= 1'b0;
         done_new <= 1'b0;
         error_code <= success;
         out_tvalid <= 1'b0;
         out_tlast <= 1'b0;
      end else begin
         state <= state_next;
         dat_out <= dat_out_next;
         dat_oe <= dat_oe_next;
         done_new <= finish;
         if (finish) begin
            done <= 1'b1;
            error_code <= finish_code;
         end
         if (set_out_tvalid)
            out_tvalid <= 1'b1;
         else if (out_tready)
            out_tvalid <= 1'b0;
         if (word_capture)
            out_tlast <= block_done;
      end
   end

   always_ff @(posedge clk) begin
      if (word_capture)
         out_tdata <= word_next;
   end

   // Card owns the bus for the whole read
   a_no_drive_in_read: assert property (@(posedge clk) disable iff (!resetn)
      state inside {state_read_pending, state_read_data, state_read_crc, state_read_end_bit}
      |-> !dat_oe);

endmodule

`default_nettype wire

// File: sd_dat_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_engine #(
   parameter int word_size = 8,
   parameter int nwr_min = 64
) (
   input  wire                      clk,
   input  wire                      resetn,
   input  wire                      sd_tick,
   input  wire                      read_mode,
   input  wire [3:0]                block_size_exp,
   input  wire [31:0]               block_count,
   input  wire                      in_tvalid,
   output wire                      in_tready,
   input  wire [word_size-1:0]      in_tdata,
   input  wire                      in_tlast,
   output wire                      out_tvalid,
   input  wire                      out_tready,
   output wire [word_size-1:0]      out_tdata,
   output wire                      out_tlast,
   input  wire sd_dat_pkg::nibble_t dat_in,
   output wire sd_dat_pkg::nibble_t dat_out,
   output wire                      dat_oe,
   output wire                      done,
   output wire                      done_new,
   output wire sd_dat_pkg::error_code_t error_code
);
   import sd_dat_pkg::*;

   wire                 count_clear;
   wire                 load_word;
   wire                 buffer_enable;
   wire                 crc_clear;
   wire nibble_t        crc_in;
   wire                 word_done;
   wire                 block_done;
   wire                 nwr_past;
   wire                 crc_done;
   wire                 resp_timeout;
   wire                 resp_done;
   wire                 last_block;
   wire nibble_t        top_nibble;
   wire [word_size-1:0] word_next;
   wire                 tlast_saved;
   wire [2:0]           line0_history;
   wire nibble_t        crc_msb;
   wire                 crc_good;

   dat_nibble_counter #(
      .word_size(word_size),
      .nwr_min(nwr_min)
   ) u_counter (
      .clk(clk),
      .resetn(resetn),
      .sd_tick(sd_tick),
      .count_clear(count_clear),
      .block_size_exp(block_size_exp),
      .block_count(block_count),
      .word_done(word_done),
      .block_done(block_done),
      .nwr_past(nwr_past),
      .crc_done(crc_done),
      .resp_timeout(resp_timeout),
      .resp_done(resp_done),
      .last_block(last_block)
   );

   dat_shift_buffer #(
      .word_size(word_size)
   ) u_buffer (
      .clk(clk),
      .resetn(resetn),
      .sd_tick(sd_tick),
      .buffer_enable(buffer_enable),
      .load_word(load_word),
      .in_tdata(in_tdata),
      .in_tlast(in_tlast),
      .dat_in(dat_in),
      .top_nibble(top_nibble),
      .word_next(word_next),
      .tlast_saved(tlast_saved),
      .line0_history(line0_history)
   );

   dat_crc16_bank u_crc (
      .clk(clk),
      .resetn(resetn),
      .crc_clear(crc_clear),
      .sd_tick(sd_tick),
      .crc_in(crc_in),
      .crc_msb(crc_msb),
      .crc_good(crc_good)
   );

   dat_sequencer #(
      .word_size(word_size)
   ) u_sequencer (
      .clk(clk),
      .resetn(resetn),
      .sd_tick(sd_tick),
      .read_mode(read_mode),
      .in_tvalid(in_tvalid),
      .out_tready(out_tready),
      .dat_in(dat_in),
      .word_done(word_done),
      .block_done(block_done),
      .nwr_past(nwr_past),
      .crc_done(crc_done),
      .resp_timeout(resp_timeout),
      .resp_done(resp_done),
      .last_block(last_block),
      .top_nibble(top_nibble),
      .word_next(word_next),
      .tlast_saved(tlast_saved),
      .line0_history(line0_history),
      .crc_msb(crc_msb),
      .crc_good(crc_good),
      .count_clear(count_clear),
      .load_word(load_word),
      .buffer_enable(buffer_enable),
      .crc_clear(crc_clear),
      .crc_in(crc_in),
      .in_tready(in_tready),
      .out_tvalid(out_tvalid),
      .out_tdata(out_tdata),
      .out_tlast(out_tlast),
      .dat_out(dat_out),
      .dat_oe(dat_oe),
      .done(done),
      .done_new(done_new),
      .error_code(error_code)
   );

endmodule

`default_nettype wire

// File: tb_sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_card_model #(
   parameter int word_size = 8,
   parameter int max_words = 64
) (
   input  wire                      clk,
   input  wire                      sd_tick,
   input  wire                      start,
   input  wire                      read_mode,
   input  wire [3:0]                block_size_exp,
   input  wire [31:0]               block_count,
   input  wire                      flip_crc,
   input  wire                      skip_status,
   input  wire                      bad_status,
   input  logic [word_size-1:0]     words [max_words],
   input  wire sd_dat_pkg::nibble_t dat_out,
   input  wire                      dat_oe,
   output sd_dat_pkg::nibble_t      dat_in,
   output logic                     busy
);
   import sd_dat_pkg::*;

   localparam int word_nibbles = word_size / 4;
   // Bus clocks to wait for a write start bit before giving up
   localparam int start_limit = 200;

   task automatic wait_tick;
      @(posedge clk);
      while (!sd_tick)
         @(posedge clk);
   endtask

   task automatic send_nibble(input nibble_t value);
      wait_tick();
      #2;
      dat_in = value;
   endtask

   // Bit-serial CRC16, message shifted in msb first
   function automatic crc_t crc_step(input crc_t crc, input logic bit_in);
      crc_step = {crc[14:0], 1'b0} ^ ((crc[15] ^ bit_in) ? crc_polynomial : 16'h0000);
   endfunction

   function automatic nibble_t data_nibble(input int block, input int i);
      logic [word_size-1:0] word;
      int nibbles;
      nibbles = 1 << block_size_exp;
      word = words[(block * nibbles + i) / word_nibbles];
      data_nibble = word[word_size - 1 - 4 * (i % word_nibbles) -: 4];
   endfunction

   task automatic send_block(input int block);
      crc_t crc [4];
      nibble_t nib;
      int nibbles;
      nibbles = 1 << block_size_exp;
      for (int l = 0; l < 4; l++)
         crc[l] = '0;
      send_nibble(4'hf);
      send_nibble(4'hf);
      send_nibble(4'h0);
      for (int i = 0; i < nibbles; i++) begin
         nib = data_nibble(block, i);
         for (int l = 0; l < 4; l++)
            crc[l] = crc_step(crc[l], nib[l]);
         send_nibble(nib);
      end
      for (int k = 0; k < crc_nibbles; k++) begin
         for (int l = 0; l < 4; l++)
            nib[l] = crc[l][15 - k];
         if (flip_crc && block == 0 && k == 5)
            nib[1] = !nib[1];
         send_nibble(nib);
      end
      send_nibble(4'hf);
   endtask

   task automatic receive_block(input int block, output logic found);
      crc_t crc [4];
      crc_t got [4];
      logic good;
      logic [2:0] status;
      int nibbles;
      nibbles = 1 << block_size_exp;
      good = 1'b1;
      found = 1'b0;
      for (int l = 0; l < 4; l++)
         crc[l] = '0;
      for (int t = 0; t < start_limit && !found; t++) begin
         wait_tick();
         found = dat_oe && dat_out == 4'h0;
      end
      if (!found)
         return;
      for (int i = 0; i < nibbles; i++) begin
         wait_tick();
         if (dat_out != data_nibble(block, i))
            good = 1'b0;
         for (int l = 0; l < 4; l++)
            crc[l] = crc_step(crc[l], dat_out[l]);
      end
      for (int k = 0; k < crc_nibbles; k++) begin
         wait_tick();
         for (int l = 0; l < 4; l++)
            got[l][15 - k] = dat_out[l];
      end
      wait_tick();
      if (dat_out != 4'hf)
         good = 1'b0;
      for (int l = 0; l < 4; l++)
         if (got[l] != crc[l])
            good = 1'b0;
      if (skip_status)
         return;
      status = (good && !bad_status) ? 3'b010 : 3'b101;
      // Token start bit right after the end bit, then status, end and busy
      #2;
      dat_in = 4'he;
      send_nibble({3'b111, status[2]});
      send_nibble({3'b111, status[1]});
      send_nibble({3'b111, status[0]});
      send_nibble(4'hf);
      send_nibble(4'he);
      send_nibble(4'he);
      send_nibble(4'hf);
   endtask

   task automatic run_transfer;
      logic found;
      for (int b = 0; b < int'(block_count); b++) begin
         if (read_mode) begin
            send_block(b);
         end else begin
            receive_block(b, found);
            if (!found)
               break;
         end
      end
      send_nibble(4'hf);
   endtask

   initial begin
      dat_in = 4'hf;
      busy = 1'b0;
      forever begin
         @(posedge clk);
         if (start) begin
            #2;
            busy = 1'b1;
            run_transfer();
            dat_in = 4'hf;
            busy = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_sd_dat_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_dat_engine;
   import sd_dat_pkg::*;

   localparam int word_size = 8;
   localparam int nwr_min = 64;
   localparam int max_words = 64;
   localparam int num_cases = 9;
   localparam int wait_limit = 40000;

   typedef enum int {
      fault_none,
      fault_crc_flip,
      fault_early_last,
      fault_no_last,
      fault_no_resp,
      fault_bad_resp,
      fault_no_ready,
      fault_drop_valid
   } fault_t;

   typedef struct {
      logic        read_mode;
      logic [3:0]  block_size_exp;
      logic [31:0] block_count;
      fault_t      fault;
      error_code_t expected;
   } case_t;

   logic                 clk;
   logic                 resetn;
   logic                 sd_tick;
   logic                 read_mode;
   logic [3:0]           block_size_exp;
   logic [31:0]          block_count;
   logic                 in_tvalid;
   wire                  in_tready;
   logic [word_size-1:0] in_tdata;
   logic                 in_tlast;
   wire                  out_tvalid;
   logic                 out_tready;
   wire [word_size-1:0]  out_tdata;
   wire                  out_tlast;
   nibble_t              dat_in;
   nibble_t              dat_out;
   wire                  dat_oe;
   wire                  done;
   wire                  done_new;
   error_code_t          error_code;

   logic                 card_start;
   logic                 card_flip;
   logic                 card_skip;
   logic                 card_bad;
   wire                  card_busy;
   logic [word_size-1:0] words [max_words];
   case_t                cases [num_cases];
   fault_t               active_fault;
   int                   tick_phase;
   int                   feed_index;
   int                   rx_index;
   int                   wpb;
   int                   total_words;

   sd_dat_engine #(
      .word_size(word_size),
      .nwr_min(nwr_min)
   ) u_sd_dat_engine (
      .clk(clk),
      .resetn(resetn),
      .sd_tick(sd_tick),
      .read_mode(read_mode),
      .block_size_exp(block_size_exp),
      .block_count(block_count),
      .in_tvalid(in_tvalid),
      .in_tready(in_tready),
      .in_tdata(in_tdata),
      .in_tlast(in_tlast),
      .out_tvalid(out_tvalid),
      .out_tready(out_tready),
      .out_tdata(out_tdata),
      .out_tlast(out_tlast),
      .dat_in(dat_in),
      .dat_out(dat_out),
      .dat_oe(dat_oe),
      .done(done),
      .done_new(done_new),
      .error_code(error_code)
   );

   tb_sd_card_model #(
      .word_size(word_size),
      .max_words(max_words)
   ) u_card (
      .clk(clk),
      .sd_tick(sd_tick),
      .start(card_start),
      .read_mode(read_mode),
      .block_size_exp(block_size_exp),
      .block_count(block_count),
      .flip_crc(card_flip),
      .skip_status(card_skip),
      .bad_status(card_bad),
      .words(words),
      .dat_out(dat_out),
      .dat_oe(dat_oe),
      .dat_in(dat_in),
      .busy(card_busy)
   );

   always #10 clk = ~clk;

   // One bus clock every four system clocks
   always @(posedge clk) begin
      #2;
      tick_phase = (tick_phase + 1) % 4;
      sd_tick = tick_phase == 3;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      lfsr_step = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
   endfunction

   task automatic fail_stop(input string message);
      $display("%s", message);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_code(input error_code_t got, input error_code_t expected);
      if (got !== expected)
         fail_stop($sformatf("Fail at %0t ns: error_code %s, expected %s",
                             $time, got.name(), expected.name()));
   endtask

   task automatic check_word(input logic [word_size-1:0] got, input logic [word_size-1:0] expected,
                             input logic got_last, input logic expected_last);
      if (got !== expected || got_last !== expected_last)
         fail_stop($sformatf("Fail at %0t ns: word %0d is %h last %b, expected %h last %b",
                             $time, rx_index, got, got_last, expected, expected_last));
   endtask

   task automatic check_flag(input string name, input logic got, input logic expected);
      if (got !== expected)
         fail_stop($sformatf("Fail at %0t ns: %s is %b, expected %b",
                             $time, name, got, expected));
   endtask

   task automatic check_count(input int got, input int expected);
      if (got != expected)
         fail_stop($sformatf("Fail at %0t ns: %0d read words accepted, expected %0d",
                             $time, got, expected));
   endtask

   task automatic present_word;
      in_tvalid = !read_mode && feed_index < total_words &&
                  !(active_fault == fault_drop_valid && feed_index >= 3);
      in_tdata = words[feed_index % max_words];
      case (active_fault)
         fault_early_last: in_tlast = feed_index == wpb - 2;
         fault_no_last:    in_tlast = 1'b0;
         default:          in_tlast = (feed_index % wpb) == wpb - 1;
      endcase
   endtask

   // Next stream word after each accept pulse
   always @(posedge clk) begin
      if (resetn && in_tready) begin
         #2;
         feed_index++;
         present_word();
      end
   end

   always @(posedge clk) begin
      if (resetn && out_tvalid && out_tready) begin
         check_word(out_tdata, words[rx_index % max_words], out_tlast,
                    (rx_index % wpb) == wpb - 1);
         rx_index++;
      end
   end

   task automatic run_case(input int index);
      case_t row;
      int waited;
      int expected_words;
      row = cases[index];
      resetn = 1'b0;
      read_mode = row.read_mode;
      block_size_exp = row.block_size_exp;
      block_count = row.block_count;
      active_fault = row.fault;
      card_flip = row.fault == fault_crc_flip;
      card_skip = row.fault == fault_no_resp;
      card_bad = row.fault == fault_bad_resp;
      out_tready = row.fault != fault_no_ready;
      wpb = (1 << row.block_size_exp) / (word_size / 4);
      total_words = wpb * int'(row.block_count);
      feed_index = 0;
      rx_index = 0;
      present_word();
      repeat (8) @(posedge clk);
      #2;
      resetn = 1'b1;
      @(posedge clk);
      #2;
      check_flag("done", done, 1'b0);
      card_start = 1'b1;
      @(posedge clk);
      #2;
      card_start = 1'b0;
      waited = 0;
      while (!done_new && waited < wait_limit) begin
         @(posedge clk);
         waited++;
      end
      if (!done_new)
         fail_stop($sformatf("Timeout in case %0d: done_new never arrived", index));
      repeat (3) @(posedge clk);
      check_code(error_code, row.expected);
      check_flag("done", done, 1'b1);
      check_flag("done_new", done_new, 1'b0);
      if (row.read_mode) begin
         case (row.fault)
            fault_crc_flip: expected_words = wpb - 1;
            fault_no_ready: expected_words = 0;
            default:        expected_words = total_words;
         endcase
         check_count(rx_index, expected_words);
      end
      waited = 0;
      while (card_busy && waited < wait_limit) begin
         @(posedge clk);
         waited++;
      end
      if (card_busy)
         fail_stop($sformatf("Timeout in case %0d: card model never went idle", index));
      #2;
   endtask

   initial begin
      logic [15:0] lfsr;
      clk = 1'b0;
      resetn = 1'b0;
      sd_tick = 1'b0;
      tick_phase = 0;
      read_mode = 1'b0;
      block_size_exp = 4'd4;
      block_count = 32'd1;
      in_tvalid = 1'b0;
      in_tdata = '0;
      in_tlast = 1'b0;
      out_tready = 1'b0;
      card_start = 1'b0;
      card_flip = 1'b0;
      card_skip = 1'b0;
      card_bad = 1'b0;
      active_fault = fault_none;
      wpb = 1;
      total_words = 0;
      lfsr = 16'd68;
      for (int w = 0; w < max_words; w++) begin
         words[w] = '0;
         for (int b = 0; b < word_size; b++) begin
            words[w] = {words[w][word_size-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
         end
      end
      cases[0] = '{1'b0, 4'd4, 32'd2, fault_none, success};
      cases[1] = '{1'b1, 4'd4, 32'd2, fault_none, success};
      cases[2] = '{1'b1, 4'd4, 32'd1, fault_crc_flip, read_bad_crc};
      cases[3] = '{1'b0, 4'd4, 32'd1, fault_early_last, write_early_boundary};
      cases[4] = '{1'b0, 4'd4, 32'd1, fault_no_last, write_late_boundary};
      cases[5] = '{1'b0, 4'd4, 32'd1, fault_no_resp, write_resp_timeout};
      cases[6] = '{1'b0, 4'd4, 32'd1, fault_bad_resp, write_bad_resp};
      cases[7] = '{1'b1, 4'd4, 32'd1, fault_no_ready, read_data_not_accepted};
      cases[8] = '{1'b0, 4'd4, 32'd1, fault_drop_valid, write_no_data};
      @(posedge clk);
      #2;
      for (int i = 0; i < num_cases; i++)
         run_case(i);
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sd_dat_engine.f
sd_dat_pkg.sv
dat_nibble_counter.sv
dat_shift_buffer.sv
dat_crc16_bank.sv
dat_sequencer.sv
sd_dat_engine.sv
tb_sd_card_model.sv
tb_sd_dat_engine.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sd_dat_engine
FILELIST  = sd_dat_engine.f
SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf obj_dir
